/* src.f */
design/periph_pkg.sv
design/timer_channel.sv
design/timer_block.sv
design/sfr_bus.sv
design/uart_tx.sv
design/uart_rx.sv
design/periph_top.sv
sim/periph_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile the peripheral and its testbench with Verilator, then run it
# The simulator exit status carries pass or fail

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -sv --top-module periph_tb \
    -f src.f -o periph_sim &&
./obj_dir/periph_sim ||
{ echo "Verilator build or simulation returned an error"; exit 1; }

/* sim/periph_tb.sv */
// Directed testbench for the 8051-style timer and serial peripheral
// Covers SFR access, timer 0 modes, and serial transmit and receive
module periph_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import periph_pkg::*;

    localparam int CLK_PERIOD = 100;
    // Timer 1 in mode 2 with TH1 = 0xFF overflows every tick, SMOD gives 16 per bit
    localparam int BIT_CLKS = 16 * CYCLE_DIV;
    // Twice 12 frames of 10 bits at 32 overflows, plus margin
    localparam int WATCHDOG_NS = 2 * 12 * 10 * 32 * CYCLE_DIV * CLK_PERIOD + 200_000;

    logic       clk;
    logic       reset_n;
    logic       sfr_sel;
    logic [7:0] sfr_addr;
    logic       sfr_we;
    logic       sfr_rd;
    sfr_data_t  sfr_wdata;
    logic       rxd;
    sfr_data_t  sfr_rdata;
    logic       sfr_ready;
    logic       tf0;
    logic       tf1;
    logic       ri;
    logic       ti;
    logic       txd;
    logic [31:0] lcg_state;

    periph_top i_periph_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    function automatic sfr_data_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input sfr_data_t act, input sfr_data_t exp);
        if (act !== exp) begin
            report_fail($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, act, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            report_fail($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, act, exp));
        end
    endtask

    // Ready comes one cycle after the access and lasts one cycle
    task automatic sfr_write(input sfr_addr_t addr, input sfr_data_t data);
        @(posedge clk);
        sfr_sel   <= 1'b1;
        sfr_we    <= 1'b1;
        sfr_addr  <= addr;
        sfr_wdata <= data;
        @(posedge clk);
        sfr_sel <= 1'b0;
        sfr_we  <= 1'b0;
        @(negedge clk);
        check_bit("sfr_ready", sfr_ready, 1'b1);
        @(negedge clk);
        check_bit("sfr_ready", sfr_ready, 1'b0);
    endtask

    task automatic sfr_read(input sfr_addr_t addr, output sfr_data_t data);
        @(posedge clk);
        sfr_sel  <= 1'b1;
        sfr_rd   <= 1'b1;
        sfr_addr <= addr;
        @(posedge clk);
        sfr_sel <= 1'b0;
        sfr_rd  <= 1'b0;
        @(negedge clk);
        data = sfr_rdata;
        check_bit("sfr_ready", sfr_ready, 1'b1);
        @(negedge clk);
        check_bit("sfr_ready", sfr_ready, 1'b0);
    endtask

    function automatic logic sample_out(input string name);
        if (name == "tf0") return tf0;
        else if (name == "tf1") return tf1;
        else if (name == "ri") return ri;
        else if (name == "ti") return ti;
        else return txd;
    endfunction

    // Poll an output at falling edges until it reaches the level
    task automatic wait_level(input string name, input logic level, input int max_clks,
                              output int clks);
        clks = 0;
        forever begin
            @(negedge clk);
            clks++;
            if (sample_out(name) === level) break;
            if (clks >= max_clks) begin
                report_fail($sformatf("Timed out after %0d clocks waiting for %s to be %0b",
                                      clks, name, level));
            end
        end
    endtask

    task automatic write_readback(input string name, input sfr_addr_t addr,
                                  input sfr_data_t data);
        sfr_data_t v;
        sfr_write(addr, data);
        sfr_read(addr, v);
        check_byte(name, v, data);
    endtask

    // Start bit, data LSB first, stop bit, then a short idle gap
    task automatic send_frame(input sfr_data_t data);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            rxd <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
        repeat (BIT_CLKS / 2) @(posedge clk);
    endtask

    task automatic register_access();
        sfr_addr_t regs[9] = '{PCON, TCON, TMOD, TL0, TL1, TH0, TH1, SCON, SBUF};
        sfr_data_t v;
        foreach (regs[k]) begin
            sfr_read(regs[k], v);
            check_byte("sfr_rdata", v, 8'h00);
        end
        write_readback("TL0", TL0, next_rand());
        write_readback("TH0", TH0, next_rand());
        write_readback("TL1", TL1, next_rand());
        write_readback("TH1", TH1, next_rand());
        write_readback("TMOD", TMOD, next_rand());
        write_readback("PCON", PCON, next_rand());
        // REN sits at bit 4 of SCON
        write_readback("SCON", SCON, 8'h10);
        sfr_write(SCON, 8'h00);
        sfr_write(TMOD, 8'h00);
        sfr_write(PCON, 8'h00);
    endtask

    task automatic timer0_mode1();
        sfr_data_t v;
        int        clks;
        sfr_write(TMOD, 8'h01);
        sfr_write(TL0, 8'hF0);
        sfr_write(TH0, 8'hFF);
        sfr_write(TCON, 8'h10);
        // 16 ticks to wrap 0xFFF0, first tick phase unknown
        wait_level("tf0", 1'b1, 20 * CYCLE_DIV, clks);
        if (clks < 15 * CYCLE_DIV || clks > 17 * CYCLE_DIV) begin
            report_fail($sformatf("Timer 0 overflow after %0d clocks, outside 15 to 17 ticks",
                                  clks));
        end
        sfr_read(TL0, v);
        if (v >= 8'h10) begin
            report_fail($sformatf("TL0 read 0x%h after overflow, expected below 0x10", v));
        end
        sfr_write(TCON, 8'h00);
        check_bit("tf0", tf0, 1'b0);
    endtask

    task automatic timer0_reload_and_13bit();
        sfr_data_t v;
        int        clks;
        int        n;
        sfr_write(TMOD, 8'h02);
        sfr_write(TH0, 8'hF0);
        sfr_write(TL0, 8'hF0);
        sfr_write(TCON, 8'h10);
        wait_level("tf0", 1'b1, 20 * CYCLE_DIV, clks);
        // Clear the flag but keep TR0, reload must bring another overflow
        sfr_write(TCON, 8'h10);
        wait_level("tf0", 1'b1, 20 * CYCLE_DIV, clks);
        for (n = 0; n < 8; n++) begin
            repeat (37) @(posedge clk);
            sfr_read(TL0, v);
            if (v < 8'hF0) begin
                report_fail($sformatf("TL0 read 0x%h in reload mode, below reload 0xF0", v));
            end
        end
        sfr_write(TCON, 8'h00);
        check_bit("tf0", tf0, 1'b0);
        // 13-bit count at its top value wraps on the first tick
        sfr_write(TMOD, 8'h00);
        sfr_write(TH0, 8'hFF);
        sfr_write(TL0, 8'h1F);
        sfr_write(TCON, 8'h10);
        wait_level("tf0", 1'b1, 2 * CYCLE_DIV, clks);
        sfr_write(TCON, 8'h00);
        check_bit("tf0", tf0, 1'b0);
    endtask

    task automatic transmit_byte();
        sfr_data_t   data;
        logic [9:0]  frame;
        int          clks;
        int          i;
        // Timer 1 overflows on every tick, SMOD halves the bit period
        sfr_write(TMOD, 8'h20);
        sfr_write(TH1, 8'hFF);
        sfr_write(TL1, 8'hFF);
        sfr_write(PCON, 8'h80);
        sfr_write(TCON, 8'h40);
        // First tick wraps TL1 at 0xFF and raises TF1
        wait_level("tf1", 1'b1, 2 * CYCLE_DIV, clks);
        data  = next_rand();
        frame = {1'b1, data, 1'b0};
        sfr_write(SBUF, data);
        wait_level("txd", 1'b0, 3 * BIT_CLKS, clks);
        repeat (BIT_CLKS / 2) @(negedge clk);
        for (i = 0; i < 10; i++) begin
            check_bit($sformatf("txd bit %0d", i), txd, frame[i]);
            if (i < 9) begin
                repeat (BIT_CLKS) @(negedge clk);
            end
        end
        wait_level("ti", 1'b1, BIT_CLKS, clks);
        sfr_write(SCON, 8'h00);
        check_bit("ti", ti, 1'b0);
    endtask

    task automatic receive_frames();
        sfr_data_t data;
        sfr_data_t v;
        int        clks;
        sfr_write(SCON, 8'h10);
        data = next_rand();
        send_frame(data);
        wait_level("ri", 1'b1, BIT_CLKS, clks);
        sfr_read(SBUF, v);
        check_byte("SBUF", v, data);
        // REN, RB8 from the stop bit, RI
        sfr_read(SCON, v);
        check_byte("SCON", v, 8'h15);
        // RI still set, the new byte is dropped
        send_frame(~data);
        sfr_read(SBUF, v);
        check_byte("SBUF", v, data);
        check_bit("ri", ri, 1'b1);
        // Receiver disabled, no frame is taken
        sfr_write(SCON, 8'h00);
        check_bit("ri", ri, 1'b0);
        send_frame(next_rand());
        repeat (BIT_CLKS) @(negedge clk);
        check_bit("ri", ri, 1'b0);
        // Stop timer 1 first so no overflow sets TF1 again during the clear
        sfr_write(TCON, 8'h00);
        sfr_write(TCON, 8'h00);
        check_bit("tf1", tf1, 1'b0);
    endtask

    initial begin
        clk       = 1'b0;
        reset_n   = 1'b0;
        sfr_sel   = 1'b0;
        sfr_addr  = 8'h00;
        sfr_we    = 1'b0;
        sfr_rd    = 1'b0;
        sfr_wdata = 8'h00;
        rxd       = 1'b1;
        lcg_state = 32'd47348;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_bit("sfr_ready", sfr_ready, 1'b0);
        check_bit("txd", txd, 1'b1);
        register_access();
        timer0_mode1();
        timer0_reload_and_13bit();
        transmit_byte();
        receive_frames();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* design/periph_top.sv */
// Top level of the 8051-style peripheral
// SFR bus decoder, two timers and the serial port
module periph_top (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  sfr_sel,
    input  logic [7:0]            sfr_addr,
    input  logic                  sfr_we,
    input  logic                  sfr_rd,
    input  periph_pkg::sfr_data_t sfr_wdata,
    input  logic                  rxd,
    output periph_pkg::sfr_data_t sfr_rdata,
    output logic                  sfr_ready,
    output logic                  tf0,
    output logic                  tf1,
    output logic                  ri,
    output logic                  ti,
    output logic                  txd
);
    import periph_pkg::*;

    // Timer controls and count read-back
    logic        tr0;
    logic        tr1;
    timer_mode_t mode0;
    timer_mode_t mode1;
    logic        tl0_wr;
    logic        th0_wr;
    logic        tl1_wr;
    logic        th1_wr;
    sfr_data_t   wdata;
    logic        tf0_clr;
    logic        tf1_clr;
    sfr_data_t   tl0;
    sfr_data_t   th0;
    sfr_data_t   tl1;
    sfr_data_t   th1;
    // Bit-rate source
    logic        t1_ovf;
    // Serial port handshake
    logic        tx_start;
    sfr_data_t   tx_data;
    logic        tx_done;
    logic        smod;
    logic        ren;
    logic        rx_done;
    sfr_data_t   rx_data;
    logic        rx_stop;

    sfr_bus     i_sfr_bus (.*);
    timer_block i_timer_block (.*);
    uart_tx     i_uart_tx (.*);
    uart_rx     i_uart_rx (.*);

endmodule

/* design/uart_rx.sv */
// Serial receiver, 10-bit asynchronous frame
// Two-flop input synchronizer and start-edge detector, a private bit-rate
// accumulator restarted at the edge so samples fall at mid-bit
module uart_rx (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  t1_ovf,
    input  logic                  smod,
    input  logic                  ren,
    input  logic                  rxd,
    output periph_pkg::sfr_data_t rx_data,
    output logic                  rx_stop,
    output logic                  rx_done
);
    import periph_pkg::*;

    rx_state_t             state;
    logic                  rxd_meta;
    logic                  rxd_sync;
    logic                  rxd_prev;
    logic                  frame_go;
    logic [BAUD_CNT_W-1:0] acc;
    logic                  acc_msb;
    logic                  bit_tick;
    logic [3:0]            bit_cnt;
    sfr_data_t             shreg;

    // Falling edge while idle and enabled opens a frame
    assign frame_go = (state == RX_IDLE) & ren & rxd_prev & ~rxd_sync;
    assign bit_tick = acc[BAUD_CNT_W-1] & ~acc_msb;
    assign rx_done  = (state == RX_DONE);
    assign rx_data  = shreg;

    // Synchronizer and edge history, idle level is high
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // Restart from 0 so the first tick comes half a bit after the edge
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc     <= '0;
            acc_msb <= 1'b0;
        end else begin
            acc_msb <= acc[BAUD_CNT_W-1];
            if (frame_go) begin
                acc <= '0;
            end else if (t1_ovf) begin
                acc <= acc + (smod ? BAUD_CNT_W'(2) : BAUD_CNT_W'(1));
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= RX_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                RX_IDLE: if (frame_go) state <= RX_START;
                // Glitch check, a high start sample drops the frame
                RX_START: if (bit_tick) begin
                    bit_cnt <= '0;
                    state   <= rxd_sync ? RX_IDLE : RX_DATA;
                end
                RX_DATA: if (bit_tick) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 4'(DATA_BITS - 1)) begin
                        state <= RX_STOP;
                    end
                end
                RX_STOP: if (bit_tick) state <= RX_DONE;
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data arrives LSB first, stop level kept for RB8
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_tick) begin
            shreg <= {rxd_sync, shreg[DATA_BITS-1:1]};
        end
        if (state == RX_STOP && bit_tick) begin
            rx_stop <= rxd_sync;
        end
    end

    // Receiver stays quiet when disabled at rest
    a_ren_off: assert property (@(posedge clk) disable iff (!reset_n)
        (state == RX_IDLE && !ren) |=> (state == RX_IDLE && !rx_done));

endmodule

/* design/uart_tx.sv */
// Serial transmitter, 10-bit asynchronous frame
// Bit rate from timer 1 overflows, 32 per bit or 16 with SMOD
// Sends start bit, 8 data bits LSB first and a high stop bit
module uart_tx (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  t1_ovf,
    input  logic                  smod,
    input  logic                  tx_start,
    input  periph_pkg::sfr_data_t tx_data,
    output logic                  txd,
    output logic                  tx_done
);
    import periph_pkg::*;

    tx_state_t             state;
    logic [BAUD_CNT_W-1:0] acc;
    logic                  acc_msb;
    logic                  bit_tick;
    logic [3:0]            bit_cnt;
    logic [DATA_BITS:0]    shreg;

    // Bit tick on the rising edge of the accumulator top bit
    assign bit_tick = acc[BAUD_CNT_W-1] & ~acc_msb;
    assign tx_done  = (state == TX_DONE);

    // Free-running overflow accumulator
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc     <= '0;
            acc_msb <= 1'b0;
        end else begin
            acc_msb <= acc[BAUD_CNT_W-1];
            if (t1_ovf) begin
                acc <= acc + (smod ? BAUD_CNT_W'(2) : BAUD_CNT_W'(1));
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= TX_IDLE;
            txd     <= 1'b1;
            bit_cnt <= '0;
        end else begin
            case (state)
                // Start requests while busy are dropped
                TX_IDLE: if (tx_start) state <= TX_WAIT;
                // Line the start bit up with a bit tick
                TX_WAIT: if (bit_tick) begin
                    txd     <= 1'b0;
                    bit_cnt <= '0;
                    state   <= TX_SHIFT;
                end
                TX_SHIFT: if (bit_tick) begin
                    // Last tick ends the stop bit
                    if (bit_cnt == 4'(DATA_BITS + 1)) begin
                        state <= TX_DONE;
                    end else begin
                        txd     <= shreg[0];
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Data with the stop bit on top, shifted out LSB first
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start) begin
            shreg <= {1'b1, tx_data};
        end else if (state == TX_SHIFT && bit_tick) begin
            shreg <= {1'b1, shreg[DATA_BITS:1]};
        end
    end

    // Line rests at mark level between frames
    a_idle_high: assert property (@(posedge clk) disable iff (!reset_n)
        (state == TX_IDLE) |-> txd);

endmodule

/* design/sfr_bus.sv */
// SFR bus decoder for the timer and serial peripheral
// Holds TMOD, PCON, TCON run bits and SCON, drives the load and clear
// strobes, and returns a registered read-back one cycle after a read
module sfr_bus (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    sfr_sel,
    input  logic [7:0]              sfr_addr,
    input  logic                    sfr_we,
    input  logic                    sfr_rd,
    input  periph_pkg::sfr_data_t   sfr_wdata,
    input  logic                    tf0,
    input  logic                    tf1,
    input  periph_pkg::sfr_data_t   tl0,
    input  periph_pkg::sfr_data_t   th0,
    input  periph_pkg::sfr_data_t   tl1,
    input  periph_pkg::sfr_data_t   th1,
    input  logic                    tx_done,
    input  logic                    rx_done,
    input  periph_pkg::sfr_data_t   rx_data,
    input  logic                    rx_stop,
    output periph_pkg::sfr_data_t   sfr_rdata,
    output logic                    sfr_ready,
    output logic                    tr0,
    output logic                    tr1,
    output periph_pkg::timer_mode_t mode0,
    output periph_pkg::timer_mode_t mode1,
    output logic                    tl0_wr,
    output logic                    th0_wr,
    output logic                    tl1_wr,
    output logic                    th1_wr,
    output periph_pkg::sfr_data_t   wdata,
    output logic                    tf0_clr,
    output logic                    tf1_clr,
    output logic                    tx_start,
    output periph_pkg::sfr_data_t   tx_data,
    output logic                    smod,
    output logic                    ren,
    output logic                    ri,
    output logic                    ti
);
    import periph_pkg::*;

    logic      wr_en;
    logic      rd_en;
    logic      tcon_wr;
    logic      scon_wr;
    logic      sbuf_wr;
    sfr_addr_t addr;
    sfr_data_t tmod;
    sfr_data_t pcon;
    sfr_data_t rx_buf;
    logic      rb8;
    sfr_data_t rd_mux;

    assign wr_en   = sfr_sel & sfr_we;
    assign rd_en   = sfr_sel & sfr_rd;
    assign addr    = sfr_addr_t'(sfr_addr);
    assign tcon_wr = wr_en & (addr == TCON);
    assign scon_wr = wr_en & (addr == SCON);
    assign sbuf_wr = wr_en & (addr == SBUF);

    // Count register loads go straight to the timers
    assign tl0_wr = wr_en & (addr == TL0);
    assign th0_wr = wr_en & (addr == TH0);
    assign tl1_wr = wr_en & (addr == TL1);
    assign th1_wr = wr_en & (addr == TH1);
    assign wdata  = sfr_wdata;

    // Writing 0 to TF1 (bit 7) or TF0 (bit 5) clears the flag
    assign tf0_clr = tcon_wr & ~sfr_wdata[5];
    assign tf1_clr = tcon_wr & ~sfr_wdata[7];

    // GATE and C/T bits are stored for read-back only
    assign mode0 = timer_mode_t'(tmod[1:0]);
    assign mode1 = timer_mode_t'(tmod[5:4]);
    assign smod  = pcon[7];

    // Read-back mux, unmapped addresses give 0
    always_comb begin
        case (addr)
            PCON:    rd_mux = pcon;
            TCON:    rd_mux = {tf1, tr1, tf0, tr0, 4'b0000};
            TMOD:    rd_mux = tmod;
            TL0:     rd_mux = tl0;
            TL1:     rd_mux = tl1;
            TH0:     rd_mux = th0;
            TH1:     rd_mux = th1;
            // SM bits and TB8 fixed at 0, only mode 1 exists
            SCON:    rd_mux = {3'b000, ren, 1'b0, rb8, ti, ri};
            SBUF:    rd_mux = rx_buf;
            default: rd_mux = '0;
        endcase
    end

    // Bus response and control registers
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sfr_ready <= 1'b0;
            sfr_rdata <= '0;
            tmod      <= '0;
            pcon      <= '0;
            tr0       <= 1'b0;
            tr1       <= 1'b0;
            ren       <= 1'b0;
            tx_start  <= 1'b0;
        end else begin
            sfr_ready <= sfr_sel & (sfr_we | sfr_rd);
            tx_start  <= sbuf_wr;
            // Read data holds until the next read
            if (rd_en) begin
                sfr_rdata <= rd_mux;
            end
            if (wr_en) begin
                case (addr)
                    TMOD: tmod <= sfr_wdata;
                    PCON: pcon <= sfr_wdata;
                    TCON: begin
                        tr1 <= sfr_wdata[6];
                        tr0 <= sfr_wdata[4];
                    end
                    SCON: ren <= sfr_wdata[4];
                    default: ;
                endcase
            end
        end
    end

    // Serial flags, a new frame is dropped while RI is still set
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ri     <= 1'b0;
            ti     <= 1'b0;
            rb8    <= 1'b0;
            rx_buf <= '0;
        end else begin
            if (rx_done && !ri) begin
                ri     <= 1'b1;
                rb8    <= rx_stop;
                rx_buf <= rx_data;
            end else if (scon_wr && !sfr_wdata[0]) begin
                ri <= 1'b0;
            end
            if (tx_done) begin
                ti <= 1'b1;
            end else if (scon_wr && !sfr_wdata[1]) begin
                ti <= 1'b0;
            end
        end
    end

    // Transmit byte for the shifter
    always_ff @(posedge clk) begin
        if (sbuf_wr) begin
            tx_data <= sfr_wdata;
        end
    end

    // At most one count register is loaded per cycle
    a_one_load: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({tl0_wr, th0_wr, tl1_wr, th1_wr}));

endmodule

/* design/timer_block.sv */
// Timer block with the machine-cycle prescaler and timers 0 and 1
// Timer 1 overflows also drive the serial bit rate
module timer_block (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    tr0,
    input  logic                    tr1,
    input  periph_pkg::timer_mode_t mode0,
    input  periph_pkg::timer_mode_t mode1,
    input  logic                    tl0_wr,
    input  logic                    th0_wr,
    input  logic                    tl1_wr,
    input  logic                    th1_wr,
    input  periph_pkg::sfr_data_t   wdata,
    input  logic                    tf0_clr,
    input  logic                    tf1_clr,
    output logic                    tf0,
    output logic                    tf1,
    output periph_pkg::sfr_data_t   tl0,
    output periph_pkg::sfr_data_t   th0,
    output periph_pkg::sfr_data_t   tl1,
    output periph_pkg::sfr_data_t   th1,
    output logic                    t1_ovf
);
    import periph_pkg::*;

    logic [$clog2(CYCLE_DIV)-1:0] pre_cnt;
    logic                         tick;
    logic                         count_en0;
    logic                         count_en1;

    // Free-running divide by CYCLE_DIV, tick on the last count
    assign tick = (pre_cnt == ($clog2(CYCLE_DIV))'(CYCLE_DIV - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pre_cnt <= '0;
        end else if (tick) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // Count only on machine ticks with the run bit set
    assign count_en0 = tick & tr0;
    assign count_en1 = tick & tr1;

    timer_channel i_timer0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .count_en (count_en0),
        .mode     (mode0),
        .tl_wr    (tl0_wr),
        .th_wr    (th0_wr),
        .wdata    (wdata),
        .tf_clr   (tf0_clr),
        .tl       (tl0),
        .th       (th0),
        .tf       (tf0),
        .ovf      ()
    );

    timer_channel i_timer1 (
        .clk      (clk),
        .reset_n  (reset_n),
        .count_en (count_en1),
        .mode     (mode1),
        .tl_wr    (tl1_wr),
        .th_wr    (th1_wr),
        .wdata    (wdata),
        .tf_clr   (tf1_clr),
        .tl       (tl1),
        .th       (th1),
        .tf       (tf1),
        .ovf      (t1_ovf)
    );

    // Machine tick is a single-clock pulse
    a_tick_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        tick |=> !tick);

endmodule

/* design/timer_channel.sv */
// One 8051 timer channel
// TH/TL count register with 13-bit, 16-bit and 8-bit auto-reload modes,
// a one-cycle overflow pulse and a sticky overflow flag
module timer_channel (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    count_en,
    input  periph_pkg::timer_mode_t mode,
    input  logic                    tl_wr,
    input  logic                    th_wr,
    input  periph_pkg::sfr_data_t   wdata,
    input  logic                    tf_clr,
    output periph_pkg::sfr_data_t   tl,
    output periph_pkg::sfr_data_t   th,
    output logic                    tf,
    output logic                    ovf
);
    import periph_pkg::*;

    logic [13:0] sum13;
    logic [16:0] sum16;
    sfr_data_t   next_tl;
    sfr_data_t   next_th;
    logic        carry;
    logic        load;
    logic        wrap;

    // Mode 0 counts TH with the low 5 bits of TL
    assign sum13 = {1'b0, th, tl[4:0]} + 14'd1;
    assign sum16 = {1'b0, th, tl} + 17'd1;
    assign load  = tl_wr | th_wr;
    // Overflow only counts when no load takes the cycle
    assign wrap  = count_en & carry & ~load;

    always_comb begin
        next_tl = tl;
        next_th = th;
        carry   = 1'b0;
        case (mode)
            MODE_13BIT: begin
                next_th      = sum13[12:5];
                next_tl[4:0] = sum13[4:0];
                carry        = sum13[13];
            end
            MODE_16BIT: begin
                {carry, next_th, next_tl} = sum16;
            end
            MODE_RELOAD8: begin
                // TH is the reload value
                carry   = &tl;
                next_tl = carry ? th : tl + 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tl  <= '0;
            th  <= '0;
            tf  <= 1'b0;
            ovf <= 1'b0;
        end else begin
            ovf <= wrap;
            // Bus load wins over counting
            if (load) begin
                if (tl_wr) begin
                    tl <= wdata;
                end
                if (th_wr) begin
                    th <= wdata;
                end
            end else if (count_en) begin
                tl <= next_tl;
                th <= next_th;
            end
            // Set beats a software clear in the same cycle
            if (wrap) begin
                tf <= 1'b1;
            end else if (tf_clr) begin
                tf <= 1'b0;
            end
        end
    end

    // Mode 3 freezes the count apart from bus loads
    a_stop_holds: assert property (@(posedge clk) disable iff (!reset_n)
        (mode == MODE_STOP && !load) |=> $stable({th, tl}));

endmodule

/* design/periph_pkg.sv */
// Shared definitions for the 8051-style timer and serial peripheral
// SFR address map, timer modes, serial FSM states and frame constants
package periph_pkg;

    // Data byte on the SFR bus and in the count and serial registers
    typedef logic [7:0] sfr_data_t;

    // Direct SFR addresses, standard 8051 locations
    typedef enum logic [7:0] {
        PCON = 8'h87,
        TCON = 8'h88,
        TMOD = 8'h89,
        TL0  = 8'h8A,
        TL1  = 8'h8B,
        TH0  = 8'h8C,
        TH1  = 8'h8D,
        SCON = 8'h98,
        SBUF = 8'h99
    } sfr_addr_t;

    // TMOD M1:M0 field, mode 3 only holds the count here
    typedef enum logic [1:0] {
        MODE_13BIT   = 2'b00,
        MODE_16BIT   = 2'b01,
        MODE_RELOAD8 = 2'b10,
        MODE_STOP    = 2'b11
    } timer_mode_t;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_WAIT,
        TX_SHIFT,
        TX_DONE
    } tx_state_t;

    // Receiver FSM
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_DONE
    } rx_state_t;

    // Clocks per machine cycle
    localparam int CYCLE_DIV  = 12;
    // Data bits per serial frame
    localparam int DATA_BITS  = 8;
    // Overflow accumulator width, 32 overflows per bit without SMOD
    localparam int BAUD_CNT_W = 5;

endpackage
